// File: dv/ntsc_capture_tb.sv
`timescale 1ns/1ps
`default_nettype none

module ntsc_capture_tb;

  logic clock_27mhz;
  logic reset;
  ntsc_pkg::word_t tv_in_ycrcb;
  wire ntsc_pkg::pixel_pair_t ntsc_pixels;
  wire ntsc_flag;
  wire ntsc_pkg::detection_t detection;
  wire frame_flag;
  wire ntsc_pkg::video_timing_t timing;
  wire ntsc_pkg::active_pixel_t pixel;

  integer seed = 32'h74976974;
  int value_errors = 0;
  int other_errors = 0;
  // Expectations are only queued and checked once the sample registers are primed
  logic armed;

  // Expected outputs in arrival order
  logic [48:0] pixel_q[$];
  logic [35:0] pair_q[$];
  logic [20:0] det_q[$];

  // Raster and sample model
  ntsc_pkg::x_t mx;
  ntsc_pkg::y_t my;
  ntsc_pkg::word_t last_cb;
  ntsc_pkg::word_t last_cr;
  ntsc_pkg::packed_pixel_t pend;
  logic phase;

  // Last XY word sent, due on the timing outputs one cycle later
  ntsc_pkg::video_timing_t xy_timing;
  logic xy_sent;
  logic xy_due;
  logic field_level;

  ntsc_capture dut0 (
    .clock_27mhz(clock_27mhz),
    .reset      (reset),
    .tv_in_ycrcb(tv_in_ycrcb),
    .ntsc_pixels(ntsc_pixels),
    .ntsc_flag  (ntsc_flag),
    .detection  (detection),
    .frame_flag (frame_flag),
    .timing     (timing),
    .pixel      (pixel)
  );

  initial
  begin
    clock_27mhz = 1'b0;
    forever #2 clock_27mhz = ~clock_27mhz;
  end

  //////////////////////////////////////////////////
  // Reference functions
  //////////////////////////////////////////////////

  // Returns {hit, class}, corners tested in fixed priority
  function automatic logic [2:0] classify(input ntsc_pkg::word_t cr, input ntsc_pkg::word_t cb);
    logic cr_hi;
    logic cr_lo;
    logic cb_hi;
    logic cb_lo;
    cr_hi = (cr > ntsc_pkg::CHROMA_HIGH);
    cr_lo = (cr < ntsc_pkg::CHROMA_LOW);
    cb_hi = (cb > ntsc_pkg::CHROMA_HIGH);
    cb_lo = (cb < ntsc_pkg::CHROMA_LOW);
    if (cr_hi && cb_hi)
      classify = 3'b100;
    else if (cr_lo && cb_hi)
      classify = 3'b101;
    else if (cr_hi && cb_lo)
      classify = 3'b110;
    else if (cr_lo && cb_lo)
      classify = 3'b111;
    else
      classify = 3'b000;
  endfunction

  // Top 8 bits of Y, top 5 of Cr and Cb
  function automatic ntsc_pkg::packed_pixel_t pack(input ntsc_pkg::word_t yv,
                                                   input ntsc_pkg::word_t cr,
                                                   input ntsc_pkg::word_t cb);
    pack = {yv[9:2], cr[9:5], cb[9:5]};
  endfunction

  // Kind 0 high corner, 1 low corner, 2 middle band, else any non-3FF word
  function automatic ntsc_pkg::word_t draw_component(input int kind);
    logic [31:0] r;
    r = $random(seed);
    case (kind)
      0: draw_component = ntsc_pkg::word_t'(32'd801 + r % 32'd222);
      1: draw_component = ntsc_pkg::word_t'(r % 32'd200);
      2: draw_component = ntsc_pkg::word_t'(32'd200 + r % 32'd601);
      default: draw_component = ntsc_pkg::word_t'(r % 32'd1023);
    endcase
  endfunction

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual)
    begin
      value_errors++;
      $display("[FAIL] %s expected %h actual %h", name, expected, actual);
    end
  endtask

  //////////////////////////////////////////////////
  // Stream generator and raster model
  //////////////////////////////////////////////////

  task automatic send_word(input ntsc_pkg::word_t w);
    @(posedge clock_27mhz);
    #1 tv_in_ycrcb = w;
  endtask

  // One pixel leaves on every Y word of a visible line
  task automatic model_pixel(input ntsc_pkg::word_t yv);
    ntsc_pkg::packed_pixel_t pp;
    logic [2:0] cls;
    if (my <= ntsc_pkg::LINE_LIMIT)
    begin
      pp = pack(yv, last_cr, last_cb);
      cls = classify(last_cr, last_cb);
      if (armed)
        pixel_q.push_back({yv, last_cr, last_cb, mx, my});
      if (armed && phase)
        pair_q.push_back({pp, pend});
      if (armed && cls[2])
        det_q.push_back({cls[1:0], mx, my});
      pend = pp;
      phase = !phase;
      mx = mx + 10'd1;
    end
  endtask

  // Preamble plus XY word, hsync taking priority over vsync
  task automatic send_header(input logic f, input logic v, input logic h);
    send_word(10'h3FF);
    send_word(10'h000);
    send_word(10'h000);
    send_word({1'b1, f, v, h, 6'b000000});
    xy_timing = {f, v, h};
    xy_sent = 1'b1;
    if (h)
    begin
      mx = '0;
      my = my + 9'd2;
    end
    else if (v)
    begin
      mx = '0;
      my = f ? 9'd0 : 9'd1;
    end
  endtask

  task automatic send_pair(input ntsc_pkg::word_t cb, input ntsc_pkg::word_t cr);
    ntsc_pkg::word_t y0;
    ntsc_pkg::word_t y1;
    y0 = draw_component(3);
    y1 = draw_component(3);
    send_word(cb);
    last_cb = cb;
    send_word(y0);
    model_pixel(y0);
    send_word(cr);
    last_cr = cr;
    send_word(y1);
    model_pixel(y1);
  endtask

  // Style 0 random kinds, 1 corner sweep, 2 middle band only
  task automatic send_line(input logic f, input int pairs, input int style);
    logic [3:0] kinds;
    send_header(f, 1'b0, 1'b1);
    send_header(f, 1'b0, 1'b0);
    for (int i = 0; i < pairs; i++)
    begin
      // Cr kind in the upper two bits, Cb kind in the lower two
      case (style == 1 ? i % 6 : 6 + style)
        0: kinds = 4'b0000;
        1: kinds = 4'b0100;
        2: kinds = 4'b0001;
        3: kinds = 4'b0101;
        4: kinds = 4'b1000;
        5: kinds = 4'b0010;
        6: kinds = 4'($unsigned($random(seed)) % 16);
        default: kinds = 4'b1010;
      endcase
      send_pair(draw_component(kinds[1:0]), draw_component(kinds[3:2]));
    end
  endtask

  task automatic wait_frame_flag(input logic level, input string what);
    int cycles;
    cycles = 0;
    while (frame_flag !== level && cycles < 8)
    begin
      @(negedge clock_27mhz);
      cycles++;
    end
    if (frame_flag !== level)
    begin
      other_errors++;
      $display("Timeout: frame_flag did not reach %0b during %s", level, what);
    end
  endtask

  //////////////////////////////////////////////////
  // Comparing process
  //////////////////////////////////////////////////

  always @(negedge clock_27mhz)
  begin
    if (!reset)
    begin
      // Field is a level taken from the last XY word
      if (xy_due)
      begin
        field_level = xy_timing.field;
        check_value("timing", xy_timing, timing);
      end
      // Sync bits only in the cycle after an XY word
      else
        check_value("timing", {field_level, 2'b00}, timing);
      xy_due = xy_sent;
      xy_sent = 1'b0;
    end
    if (!reset && armed)
    begin
      if (pixel.valid && pixel_q.size() == 0)
      begin
        other_errors++;
        $display("Unexpected pixel strobe at x %0d y %0d", pixel.x, pixel.y);
      end
      else if (pixel.valid)
        check_value("pixel", pixel_q.pop_front(), {pixel.sample, pixel.x, pixel.y});
      if (ntsc_flag && pair_q.size() == 0)
      begin
        other_errors++;
        $display("Unexpected packed word flag");
      end
      else if (ntsc_flag)
        check_value("ntsc_pixels", pair_q.pop_front(), ntsc_pixels);
      if (detection.flag && det_q.size() == 0)
      begin
        other_errors++;
        $display("Unexpected detection at x %0d y %0d", detection.x, detection.y);
      end
      else if (detection.flag)
        check_value("detection", det_q.pop_front(),
                    {detection.color, detection.x, detection.y});
    end
  end

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial
  begin
    int cycles;
    armed = 1'b0;
    reset = 1'b1;
    tv_in_ycrcb = '0;
    mx = '0;
    my = '0;
    last_cb = '0;
    last_cr = '0;
    pend = '0;
    phase = 1'b0;
    xy_timing = '0;
    xy_sent = 1'b0;
    xy_due = 1'b0;
    field_level = 1'b0;
    repeat (4) @(posedge clock_27mhz);
    #1 reset = 1'b0;
    @(negedge clock_27mhz);
    check_value("reset ntsc_flag", 0, ntsc_flag);
    check_value("reset detection.flag", 0, detection.flag);
    check_value("reset frame_flag", 0, frame_flag);
    check_value("reset pixel.valid", 0, pixel.valid);

    // Priming line loads Cr, middle Cb keeps it out of every corner
    send_header(1'b1, 1'b0, 1'b1);
    send_header(1'b1, 1'b0, 1'b0);
    send_pair(draw_component(2), draw_component(3));
    // Even field vsync, y restarts at 0
    send_header(1'b1, 1'b1, 1'b0);
    wait_frame_flag(1'b1, "even field vsync");
    repeat (6) send_word(10'h080);
    armed = 1'b1;

    send_line(1'b1, 8, 1);
    send_line(1'b1, 5, 0);
    // Abort after three pixels, then junk until the next preamble
    send_header(1'b1, 1'b0, 1'b1);
    send_header(1'b1, 1'b0, 1'b0);
    send_pair(draw_component(0), draw_component(0));
    last_cb = draw_component(1);
    send_word(last_cb);
    send_pair_abort_y: begin
      ntsc_pkg::word_t y0;
      y0 = draw_component(3);
      send_word(y0);
      model_pixel(y0);
    end
    send_word(10'h3FF);
    repeat (3) send_word(10'h155);
    send_line(1'b1, 4, 2);

    // Empty lines down to the bottom of the even field
    while (my < 9'd478)
      send_header(1'b1, 1'b0, 1'b1);
    // Line 478 is still below the frame threshold
    repeat (3) send_word(10'h080);
    check_value("frame_flag at line 478", 0, frame_flag);
    send_line(1'b1, 2, 1);
    send_line(1'b1, 3, 1);
    wait_frame_flag(1'b1, "even field past line 479");

    // Odd field starts on line 1
    send_header(1'b0, 1'b1, 1'b0);
    wait_frame_flag(1'b0, "odd field vsync");
    send_line(1'b0, 3, 0);
    send_line(1'b0, 3, 1);
    send_header(1'b0, 1'b0, 1'b1);
    repeat (4) send_word(10'h080);

    cycles = 0;
    while ((pixel_q.size() + pair_q.size() + det_q.size()) != 0 && cycles < 100)
    begin
      @(negedge clock_27mhz);
      cycles++;
    end
    if ((pixel_q.size() + pair_q.size() + det_q.size()) != 0)
    begin
      other_errors++;
      $display("Timeout: %0d pixels, %0d packed words and %0d detections never arrived",
               pixel_q.size(), pair_q.size(), det_q.size());
    end

    $display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: ntsc_capture.f
verilog/ntsc_pkg.sv
verilog/ccir656_decoder.sv
verilog/raster_counter.sv
verilog/pixel_pair_packer.sv
verilog/chroma_classifier.sv
verilog/ntsc_capture.sv
dv/ntsc_capture_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  --top-module ntsc_capture_tb -f ntsc_capture.f -o Vntsc_capture_tb
./obj_dir/Vntsc_capture_tb > sim.log 2>&1 || true
cat sim.log
if grep -q "TEST RESULT: PASS" sim.log; then
  echo "Simulation passed"
  exit 0
fi
echo "Simulation failed"
exit 1

// File: verilog/ccir656_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module ccir656_decoder (
  input  wire                     clock_27mhz,
  input  wire                     reset,
  input  wire ntsc_pkg::word_t    tv_in_ycrcb,
  output ntsc_pkg::ycrcb_t        sample,
  output logic                    sample_valid,
  output ntsc_pkg::video_timing_t timing
);

  ntsc_pkg::decode_state_t state;
  ntsc_pkg::decode_state_t state_next;
  logic is_ff;
  logic is_00;
  logic y_word;

  assign is_ff = (tv_in_ycrcb == ntsc_pkg::SAV_PREAMBLE_FF);
  assign is_00 = (tv_in_ycrcb == ntsc_pkg::SAV_PREAMBLE_00);

  // A Y word completes one sample, unless a new preamble cuts in
  assign y_word = !is_ff &&
                  ((state == ntsc_pkg::ACTIVE_Y0) || (state == ntsc_pkg::ACTIVE_Y1));

  //////////////////////////////////////////////////
  // Preamble and XY state machine
  //////////////////////////////////////////////////

  always_comb
  begin
    // Anything unexpected falls back to the start of the preamble
    state_next = ntsc_pkg::SYNC_FF;
    case (state)
      ntsc_pkg::SYNC_FF:
        if (is_ff)
          state_next = ntsc_pkg::SYNC_00A;
      ntsc_pkg::SYNC_00A:
        if (is_00)
          state_next = ntsc_pkg::SYNC_00B;
        else if (is_ff)
          state_next = ntsc_pkg::SYNC_00A;
      ntsc_pkg::SYNC_00B:
        if (is_00)
          state_next = ntsc_pkg::XY;
        else if (is_ff)
          state_next = ntsc_pkg::SYNC_00A;
      // Only an SAV with V and H clear opens active video
      ntsc_pkg::XY:
        if (!tv_in_ycrcb[ntsc_pkg::XY_V_BIT] && !tv_in_ycrcb[ntsc_pkg::XY_H_BIT])
          state_next = ntsc_pkg::ACTIVE_CB;
      // Active video cycles Cb, Y, Cr, Y; a 3FF starts the next preamble
      ntsc_pkg::ACTIVE_CB:
        state_next = is_ff ? ntsc_pkg::SYNC_00A : ntsc_pkg::ACTIVE_Y0;
      ntsc_pkg::ACTIVE_Y0:
        state_next = is_ff ? ntsc_pkg::SYNC_00A : ntsc_pkg::ACTIVE_CR;
      ntsc_pkg::ACTIVE_CR:
        state_next = is_ff ? ntsc_pkg::SYNC_00A : ntsc_pkg::ACTIVE_Y1;
      ntsc_pkg::ACTIVE_Y1:
        state_next = is_ff ? ntsc_pkg::SYNC_00A : ntsc_pkg::ACTIVE_CB;
      default:
        state_next = ntsc_pkg::SYNC_FF;
    endcase
  end

  always_ff @(posedge clock_27mhz)
  begin
    if (reset)
    begin
      state <= ntsc_pkg::SYNC_FF;
      sample_valid <= 1'b0;
      timing <= '0;
    end
    else
    begin
      state <= state_next;
      sample_valid <= y_word;
      // Sync pulses last one cycle
      timing.vsync <= 1'b0;
      timing.hsync <= 1'b0;
      if (state == ntsc_pkg::XY)
      begin
        // Field holds until the next XY word
        timing.field <= tv_in_ycrcb[ntsc_pkg::XY_F_BIT];
        timing.vsync <= tv_in_ycrcb[ntsc_pkg::XY_V_BIT];
        timing.hsync <= tv_in_ycrcb[ntsc_pkg::XY_H_BIT];
      end
    end
  end

  // Sample components, each loaded in its own slot
  always_ff @(posedge clock_27mhz)
  begin
    if (!is_ff)
    begin
      case (state)
        ntsc_pkg::ACTIVE_CB:
          sample.cb <= tv_in_ycrcb;
        ntsc_pkg::ACTIVE_CR:
          sample.cr <= tv_in_ycrcb;
        ntsc_pkg::ACTIVE_Y0, ntsc_pkg::ACTIVE_Y1:
          sample.y <= tv_in_ycrcb;
        default:
          sample <= sample;
      endcase
    end
  end

  // Y words come every second word, so valid strobes are never adjacent
  sample_valid_spaced: assert property (
    @(posedge clock_27mhz) disable iff (reset) sample_valid |=> !sample_valid);

endmodule

`default_nettype wire

// File: verilog/chroma_classifier.sv
`timescale 1ns/1ps
`default_nettype none

module chroma_classifier (
  input  wire                          clock_27mhz,
  input  wire                          reset,
  input  wire ntsc_pkg::active_pixel_t pixel,
  output ntsc_pkg::detection_t         detection
);

  logic cr_high;
  logic cr_low;
  logic cb_high;
  logic cb_low;
  logic corner_hit;
  ntsc_pkg::color_class_t corner;

  // Strict comparisons, the threshold values themselves are middle band
  assign cr_high = (pixel.sample.cr > ntsc_pkg::CHROMA_HIGH);
  assign cr_low = (pixel.sample.cr < ntsc_pkg::CHROMA_LOW);
  assign cb_high = (pixel.sample.cb > ntsc_pkg::CHROMA_HIGH);
  assign cb_low = (pixel.sample.cb < ntsc_pkg::CHROMA_LOW);

  //////////////////////////////////////////////////
  // Corner lookup in the Cr/Cb plane
  //////////////////////////////////////////////////

  always_comb
  begin
    corner_hit = 1'b1;
    corner = ntsc_pkg::UPPER_RIGHT;
    if (cr_high && cb_high)
      corner = ntsc_pkg::UPPER_RIGHT;
    else if (cr_low && cb_high)
      corner = ntsc_pkg::UPPER_LEFT;
    else if (cr_high && cb_low)
      corner = ntsc_pkg::LOWER_RIGHT;
    else if (cr_low && cb_low)
      corner = ntsc_pkg::LOWER_LEFT;
    else
      corner_hit = 1'b0;
  end

  always_ff @(posedge clock_27mhz)
  begin
    if (reset)
      detection.flag <= 1'b0;
    else
      detection.flag <= pixel.valid && corner_hit;
  end

  // Class and position hold until the next hit
  always_ff @(posedge clock_27mhz)
  begin
    if (pixel.valid && corner_hit)
    begin
      detection.color <= corner;
      detection.x <= pixel.x;
      detection.y <= pixel.y;
    end
  end

endmodule

`default_nettype wire

// File: verilog/ntsc_capture.sv
`timescale 1ns/1ps
`default_nettype none

module ntsc_capture (
  input  wire                           clock_27mhz,
  input  wire                           reset,
  input  wire ntsc_pkg::word_t          tv_in_ycrcb,
  output wire ntsc_pkg::pixel_pair_t    ntsc_pixels,
  output wire                           ntsc_flag,
  output wire ntsc_pkg::detection_t     detection,
  output wire                           frame_flag,
  output wire ntsc_pkg::video_timing_t  timing,
  output wire ntsc_pkg::active_pixel_t  pixel
);

  ntsc_pkg::ycrcb_t sample;
  logic sample_valid;

  //////////////////////////////////////////////////
  // Decode, position, then the two pixel consumers
  //////////////////////////////////////////////////

  ccir656_decoder decoder0 (
    .clock_27mhz (clock_27mhz),
    .reset       (reset),
    .tv_in_ycrcb (tv_in_ycrcb),
    .sample      (sample),
    .sample_valid(sample_valid),
    .timing      (timing)
  );

  raster_counter raster0 (
    .clock_27mhz (clock_27mhz),
    .reset       (reset),
    .sample      (sample),
    .sample_valid(sample_valid),
    .timing      (timing),
    .pixel       (pixel),
    .frame_flag  (frame_flag)
  );

  // Both consumers see every active pixel
  pixel_pair_packer packer0 (
    .clock_27mhz(clock_27mhz),
    .reset      (reset),
    .pixel      (pixel),
    .ntsc_pixels(ntsc_pixels),
    .ntsc_flag  (ntsc_flag)
  );

  chroma_classifier classifier0 (
    .clock_27mhz(clock_27mhz),
    .reset      (reset),
    .pixel      (pixel),
    .detection  (detection)
  );

endmodule

`default_nettype wire

// File: verilog/ntsc_pkg.sv
`default_nettype none

package ntsc_pkg;

  //////////////////////////////////////////////////
  // CCIR656 word stream
  //////////////////////////////////////////////////

  localparam int WORD_WIDTH = 10;

  // One word from the decoder chip, or one Y, Cr or Cb component
  typedef logic [WORD_WIDTH-1:0] word_t;

  // Preamble is 3FF, 000, 000 and then the XY word
  localparam word_t SAV_PREAMBLE_FF = 10'h3FF;
  localparam word_t SAV_PREAMBLE_00 = 10'h000;

  // Bit positions inside the XY word
  localparam int XY_F_BIT = 8;
  localparam int XY_V_BIT = 7;
  localparam int XY_H_BIT = 6;

  //////////////////////////////////////////////////
  // Raster and pixel formats
  //////////////////////////////////////////////////

  // Last line that is still captured
  localparam int LINE_LIMIT = 480;
  localparam int X_WIDTH = 10;
  localparam int Y_WIDTH = 9;

  typedef logic [X_WIDTH-1:0] x_t;
  typedef logic [Y_WIDTH-1:0] y_t;

  // Corner thresholds of the Cr/Cb plane
  localparam word_t CHROMA_HIGH = 10'd800;
  localparam word_t CHROMA_LOW = 10'd200;

  // Bits kept from the top of each component when packing
  localparam int PACK_Y_BITS = 8;
  localparam int PACK_C_BITS = 5;

  typedef enum logic [2:0] {
    SYNC_FF,
    SYNC_00A,
    SYNC_00B,
    XY,
    ACTIVE_CB,
    ACTIVE_Y0,
    ACTIVE_CR,
    ACTIVE_Y1
  } decode_state_t;

  typedef enum logic [1:0] {
    UPPER_RIGHT = 2'd0,
    UPPER_LEFT = 2'd1,
    LOWER_RIGHT = 2'd2,
    LOWER_LEFT = 2'd3
  } color_class_t;

  typedef struct packed {
    word_t y;
    word_t cr;
    word_t cb;
  } ycrcb_t;

  // Field is a level, vsync and hsync are single-cycle pulses
  typedef struct packed {
    logic field;
    logic vsync;
    logic hsync;
  } video_timing_t;

  typedef struct packed {
    logic valid;
    ycrcb_t sample;
    x_t x;
    y_t y;
  } active_pixel_t;

  typedef struct packed {
    logic [PACK_Y_BITS-1:0] y;
    logic [PACK_C_BITS-1:0] cr;
    logic [PACK_C_BITS-1:0] cb;
  } packed_pixel_t;

  // Second pixel sits in the upper half
  typedef struct packed {
    packed_pixel_t second;
    packed_pixel_t first;
  } pixel_pair_t;

  typedef struct packed {
    color_class_t color;
    x_t x;
    y_t y;
    logic flag;
  } detection_t;

endpackage

`default_nettype wire

// File: verilog/pixel_pair_packer.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_pair_packer (
  input  wire                          clock_27mhz,
  input  wire                          reset,
  input  wire ntsc_pkg::active_pixel_t pixel,
  output ntsc_pkg::pixel_pair_t        ntsc_pixels,
  output logic                         ntsc_flag
);

  ntsc_pkg::packed_pixel_t packed_in;
  // Low when the next pixel goes to the first half
  logic second_phase;

  // Keep only the top bits of each component
  always_comb
  begin
    packed_in.y = pixel.sample.y[ntsc_pkg::WORD_WIDTH-1 -: ntsc_pkg::PACK_Y_BITS];
    packed_in.cr = pixel.sample.cr[ntsc_pkg::WORD_WIDTH-1 -: ntsc_pkg::PACK_C_BITS];
    packed_in.cb = pixel.sample.cb[ntsc_pkg::WORD_WIDTH-1 -: ntsc_pkg::PACK_C_BITS];
  end

  always_ff @(posedge clock_27mhz)
  begin
    if (reset)
    begin
      second_phase <= 1'b0;
      ntsc_flag <= 1'b0;
    end
    else
    begin
      ntsc_flag <= 1'b0;
      if (pixel.valid)
      begin
        second_phase <= !second_phase;
        // Word is complete after the second pixel
        ntsc_flag <= second_phase;
      end
    end
  end

  always_ff @(posedge clock_27mhz)
  begin
    if (pixel.valid && !second_phase)
      ntsc_pixels.first <= packed_in;
    if (pixel.valid && second_phase)
      ntsc_pixels.second <= packed_in;
  end

  // One packed word per two pixels
  ntsc_flag_spaced: assert property (
    @(posedge clock_27mhz) disable iff (reset) ntsc_flag |=> !ntsc_flag);

endmodule

`default_nettype wire

// File: verilog/raster_counter.sv
`timescale 1ns/1ps
`default_nettype none

module raster_counter (
  input  wire                          clock_27mhz,
  input  wire                          reset,
  input  wire ntsc_pkg::ycrcb_t        sample,
  input  wire                          sample_valid,
  input  wire ntsc_pkg::video_timing_t timing,
  output ntsc_pkg::active_pixel_t      pixel,
  output logic                         frame_flag
);

  ntsc_pkg::x_t x;
  ntsc_pkg::y_t y;
  logic line_visible;

  // Lines past LINE_LIMIT are blanked
  assign line_visible = (y <= ntsc_pkg::LINE_LIMIT);

  //////////////////////////////////////////////////
  // Interlaced position tracking
  //////////////////////////////////////////////////

  always_ff @(posedge clock_27mhz)
  begin
    if (reset)
    begin
      x <= '0;
      y <= '0;
      pixel.valid <= 1'b0;
      frame_flag <= 1'b0;
    end
    else
    begin
      pixel.valid <= 1'b0;
      if (sample_valid && line_visible)
      begin
        // Position before the increment goes out with the sample
        pixel.valid <= 1'b1;
        x <= x + 1'b1;
      end
      // Even field (f=1) starts on line 0, odd field on line 1
      if (timing.vsync)
      begin
        x <= '0;
        y <= timing.field ? ntsc_pkg::y_t'(0) : ntsc_pkg::y_t'(1);
      end
      // Hsync has the last word, lines interleave by two
      if (timing.hsync)
      begin
        x <= '0;
        y <= y + 2'd2;
      end
      // Even field done once past line 479 or in its vertical sync
      frame_flag <= timing.field && ((y >= ntsc_pkg::LINE_LIMIT) || timing.vsync);
    end
  end

  // Payload of the pixel strobe
  always_ff @(posedge clock_27mhz)
  begin
    if (sample_valid && line_visible)
    begin
      pixel.sample <= sample;
      pixel.x <= x;
      pixel.y <= y;
    end
  end

  pixel_in_visible_lines: assert property (
    @(posedge clock_27mhz) disable iff (reset)
    pixel.valid |-> (pixel.y <= ntsc_pkg::LINE_LIMIT));

endmodule

`default_nettype wire
